//--- common/fruit_params.svh
`ifndef FRUIT_PARAMS_SVH
`define FRUIT_PARAMS_SVH

// system clock in MHz
`define FRUIT_CLK_FRE_MHZ 50
// host link speed
`define FRUIT_BAUD_RATE 115200
// clock cycles per uart bit
`define FRUIT_CLKS_PER_BIT (`FRUIT_CLK_FRE_MHZ * 1000000 / `FRUIT_BAUD_RATE)

// first byte of every report frame
`define FRUIT_REPORT_HDR 8'hA5

// host command bytes, "Q" and "0"
`define FRUIT_CMD_QUERY 8'h51
`define FRUIT_CMD_MODE_BASE 8'h30

`endif

//--- common/fruit_pkg.sv
`default_nettype none

package fruit_pkg;

        // detection mode, code 3 unused
        typedef enum logic [1:0] {
                MODE_COUNT  = 2'd0,
                MODE_COLOR  = 2'd1,
                MODE_DETECT = 2'd2
        } mode_e;

        // decoded host command
        typedef enum logic {
                CMD_QUERY    = 1'b0,
                CMD_SET_MODE = 1'b1
        } cmd_kind_e;

        // one byte on the report link
        typedef logic [7:0] report_byte_t;

endpackage

`default_nettype wire

//--- common/uart_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded command from receiver to executor
interface uart_cmd_if;
        import fruit_pkg::*;

        logic      cmd_valid;
        logic      cmd_ready;
        // payload, stable while valid
        cmd_kind_e cmd_kind;
        mode_e     cmd_mode;

        // receiver holds valid until ready
        modport rx_side (
                output cmd_valid,
                output cmd_kind,
                output cmd_mode,
                input  cmd_ready
        );

        // executor only takes commands when idle
        modport exec_side (
                input  cmd_valid,
                input  cmd_kind,
                input  cmd_mode,
                output cmd_ready
        );

endinterface

`default_nettype wire

//--- uart/uart_rx_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "fruit_params.svh"

module uart_rx_decode #(
        parameter int CLKS_PER_BIT = `FRUIT_CLKS_PER_BIT
) (
        input  wire         sys_clk_i,
        input  wire         arst_n_i,
        input  wire         uart_rx_i,
        uart_cmd_if.rx_side cmd_o
);
        import fruit_pkg::*;

        localparam int CNT_W = $clog2(CLKS_PER_BIT);
        localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
        localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

        typedef enum logic [1:0] {
                RX_IDLE,
                RX_START,
                RX_DATA,
                RX_STOP
        } rx_state_e;

        rx_state_e        state;
        logic             rx_meta;
        logic             rx_sync;
        logic [CNT_W-1:0] clk_cnt;
        logic [2:0]       bit_idx;
        logic [7:0]       rx_byte;
        logic             stop_hit;
        logic             is_query;
        logic             is_mode;
        logic             cmd_load;

        // two flop sync, line idles high
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        rx_meta <= 1'b1;
                        rx_sync <= 1'b1;
                end else begin
                        rx_meta <= uart_rx_i;
                        rx_sync <= rx_meta;
                end
        end

        // bit timing, half a bit to reach the middle of start
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        state   <= RX_IDLE;
                        clk_cnt <= '0;
                        bit_idx <= '0;
                end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                        case (state)
                        RX_IDLE: begin
                                clk_cnt <= '0;
                                if (!rx_sync)
                                        state <= RX_START;
                        end
                        RX_START: begin
                                if (clk_cnt == HALF_LAST) begin
                                        clk_cnt <= '0;
                                        bit_idx <= '0;
                                        // glitch, not a real start bit
                                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                                end
                        end
                        RX_DATA: begin
                                if (clk_cnt == BIT_LAST) begin
                                        clk_cnt <= '0;
                                        bit_idx <= bit_idx + 1'b1;
                                        if (bit_idx == 3'd7)
                                                state <= RX_STOP;
                                end
                        end
                        default: begin
                                // middle of stop bit, back to idle
                                if (stop_hit)
                                        state <= RX_IDLE;
                        end
                        endcase
                end
        end

        // lsb first shift
        always_ff @(posedge sys_clk_i) begin
                if (state == RX_DATA && clk_cnt == BIT_LAST)
                        rx_byte <= {rx_sync, rx_byte[7:1]};
        end

        assign stop_hit = (state == RX_STOP) && (clk_cnt == BIT_LAST);
        assign is_query = (rx_byte == `FRUIT_CMD_QUERY);
        assign is_mode  = (rx_byte >= `FRUIT_CMD_MODE_BASE) &&
                          (rx_byte <= `FRUIT_CMD_MODE_BASE + 8'd2);
        // bad stop bit, unknown byte or pending command: nothing
        assign cmd_load = stop_hit && rx_sync && (is_query || is_mode) && !cmd_o.cmd_valid;

        // single command buffer
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i)
                        cmd_o.cmd_valid <= 1'b0;
                else if (cmd_load)
                        cmd_o.cmd_valid <= 1'b1;
                else if (cmd_o.cmd_ready)
                        cmd_o.cmd_valid <= 1'b0;
        end

        always_ff @(posedge sys_clk_i) begin
                if (cmd_load) begin
                        cmd_o.cmd_kind <= is_query ? CMD_QUERY : CMD_SET_MODE;
                        // "0".."2" map to the low two bits
                        cmd_o.cmd_mode <= mode_e'(rx_byte[1:0]);
                end
        end

        // executor sees one steady command until it takes it
        a_cmd_hold: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
                cmd_o.cmd_valid && !cmd_o.cmd_ready |=> cmd_o.cmd_valid &&
                $stable(cmd_o.cmd_kind) && $stable(cmd_o.cmd_mode));

endmodule

`default_nettype wire

//--- uart/uart_tx_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "fruit_params.svh"

module uart_tx_result #(
        parameter int CLKS_PER_BIT = `FRUIT_CLKS_PER_BIT
) (
        input  wire                     sys_clk_i,
        input  wire                     arst_n_i,
        input  wire                     tx_valid_i,
        input  wire fruit_pkg::report_byte_t tx_data_i,
        output logic                    tx_ready_o,
        output logic                    uart_tx_o
);
        localparam int CNT_W = $clog2(CLKS_PER_BIT);
        localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

        logic             busy;
        logic [CNT_W-1:0] clk_cnt;
        logic [3:0]       bit_cnt;
        // data bits then stop bit
        logic [8:0]       tx_shift;

        assign tx_ready_o = !busy;

        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        busy      <= 1'b0;
                        clk_cnt   <= '0;
                        bit_cnt   <= '0;
                        uart_tx_o <= 1'b1;
                end else if (!busy) begin
                        if (tx_valid_i) begin
                                // start bit from the next cycle
                                busy      <= 1'b1;
                                clk_cnt   <= '0;
                                bit_cnt   <= '0;
                                uart_tx_o <= 1'b0;
                        end
                end else if (clk_cnt == BIT_LAST) begin
                        clk_cnt <= '0;
                        // stop bit done after ten bit times
                        if (bit_cnt == 4'd9) begin
                                busy <= 1'b0;
                        end else begin
                                bit_cnt   <= bit_cnt + 1'b1;
                                uart_tx_o <= tx_shift[0];
                        end
                end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                end
        end

        always_ff @(posedge sys_clk_i) begin
                if (!busy && tx_valid_i)
                        tx_shift <= {1'b1, tx_data_i};
                else if (busy && clk_cnt == BIT_LAST)
                        tx_shift <= {1'b1, tx_shift[8:1]};
        end

        // host must see a mark line between frames
        a_idle_high: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
                !busy |-> uart_tx_o);

endmodule

`default_nettype wire

//--- verilog/mode_key_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mode_key_ctrl #(
        parameter int DEBOUNCE_CYCLES = 1_000_000
) (
        input  wire                   sys_clk_i,
        input  wire                   arst_n_i,
        input  wire [1:0]             key_button_i,
        input  wire                   mode_set_i,
        input  wire fruit_pkg::mode_e mode_set_val_i,
        output fruit_pkg::mode_e      mode_o,
        output logic [2:0]            led_out_o
);
        import fruit_pkg::*;

        localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
        localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES);

        logic [1:0]       key_meta;
        logic [1:0]       key_sync;
        logic [CNT_W-1:0] key_cnt [2];
        // one pulse per press
        logic [1:0]       key_evt;
        mode_e            mode_q;
        mode_e            mode_next;
        mode_e            mode_prev;

        // keys are active low, released reads high
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        key_meta <= 2'b11;
                        key_sync <= 2'b11;
                        key_evt  <= 2'b00;
                        key_cnt  <= '{default: '0};
                end else begin
                        key_meta <= key_button_i;
                        key_sync <= key_meta;
                        for (int i = 0; i < 2; i++) begin
                                if (!key_sync[i]) begin
                                        // saturate, so a held key fires once
                                        if (key_cnt[i] != CNT_MAX)
                                                key_cnt[i] <= key_cnt[i] + 1'b1;
                                        key_evt[i] <= (key_cnt[i] == CNT_MAX - 1'b1);
                                end else begin
                                        // release rearms the key
                                        key_cnt[i] <= '0;
                                        key_evt[i] <= 1'b0;
                                end
                        end
                end
        end

        // wrap order count, color, detect
        always_comb begin
                case (mode_q)
                MODE_COUNT: begin
                        mode_next = MODE_COLOR;
                        mode_prev = MODE_DETECT;
                end
                MODE_COLOR: begin
                        mode_next = MODE_DETECT;
                        mode_prev = MODE_COUNT;
                end
                default: begin
                        mode_next = MODE_COUNT;
                        mode_prev = MODE_COLOR;
                end
                endcase
        end

        // uart set request beats a key
        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i)
                        mode_q <= MODE_COUNT;
                else if (mode_set_i)
                        mode_q <= mode_set_val_i;
                else if (key_evt[0])
                        mode_q <= mode_next;
                else if (key_evt[1])
                        mode_q <= mode_prev;
        end

        assign mode_o = mode_q;
        // one hot, bit 0 count
        assign led_out_o = {mode_q == MODE_DETECT, mode_q == MODE_COLOR, mode_q == MODE_COUNT};

        // set requests come from decoded "0".."2" only
        a_mode_legal: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
                mode_q != 2'd3);

endmodule

`default_nettype wire

//--- verilog/report_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "fruit_params.svh"

module report_exec (
        input  wire                          sys_clk_i,
        input  wire                          arst_n_i,
        uart_cmd_if.exec_side                cmd_i,
        input  wire fruit_pkg::mode_e        mode_i,
        input  wire [7:0]                    fruit_number_i,
        input  wire [2:0]                    color_i,
        input  wire                          tx_ready_i,
        output logic                         mode_set_o,
        output fruit_pkg::mode_e             mode_set_val_o,
        output logic                         tx_valid_o,
        output fruit_pkg::report_byte_t      tx_data_o
);
        import fruit_pkg::*;

        typedef enum logic {
                EX_IDLE,
                EX_SEND
        } ex_state_e;

        ex_state_e    state;
        // header, mode, payload, checksum
        logic [1:0]   byte_idx;
        mode_e        rpt_mode;
        logic [7:0]   rpt_num;
        logic [2:0]   rpt_color;
        report_byte_t payload;
        report_byte_t csum;
        logic         cmd_take;
        logic         tx_take;

        assign cmd_i.cmd_ready = (state == EX_IDLE);
        assign cmd_take        = cmd_i.cmd_valid && cmd_i.cmd_ready;
        assign tx_take         = tx_valid_o && tx_ready_i;
        assign tx_valid_o      = (state == EX_SEND);

        // mode register updates on the accept edge
        assign mode_set_o     = cmd_take && (cmd_i.cmd_kind == CMD_SET_MODE);
        assign mode_set_val_o = cmd_i.cmd_mode;

        always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        state    <= EX_IDLE;
                        byte_idx <= '0;
                end else if (state == EX_IDLE) begin
                        byte_idx <= '0;
                        if (cmd_take && cmd_i.cmd_kind == CMD_QUERY)
                                state <= EX_SEND;
                end else if (tx_take) begin
                        byte_idx <= byte_idx + 1'b1;
                        // checksum gone, report done
                        if (byte_idx == 2'd3)
                                state <= EX_IDLE;
                end
        end

        // snapshot inputs so the frame is self consistent
        always_ff @(posedge sys_clk_i) begin
                if (cmd_take && cmd_i.cmd_kind == CMD_QUERY) begin
                        rpt_mode  <= mode_i;
                        rpt_num   <= fruit_number_i;
                        rpt_color <= color_i;
                end
        end

        // running sum of header, mode and payload
        always_ff @(posedge sys_clk_i) begin
                if (cmd_take)
                        csum <= '0;
                else if (tx_take)
                        csum <= csum + tx_data_o;
        end

        always_comb begin
                case (rpt_mode)
                MODE_COUNT:  payload = rpt_num;
                MODE_COLOR:  payload = {5'b0, rpt_color};
                MODE_DETECT: payload = {7'b0, rpt_num != 8'd0};
                default:     payload = '0;
                endcase
        end

        always_comb begin
                case (byte_idx)
                2'd0:    tx_data_o = `FRUIT_REPORT_HDR;
                2'd1:    tx_data_o = {6'b0, rpt_mode};
                2'd2:    tx_data_o = payload;
                default: tx_data_o = csum;
                endcase
        end

        // byte must not move under the transmitter
        a_tx_stable: assert property (@(posedge sys_clk_i) disable iff (!arst_n_i)
                tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

`default_nettype wire

//--- verilog/fruit_report_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "fruit_params.svh"

module fruit_report_top #(
        parameter int CLKS_PER_BIT    = `FRUIT_CLKS_PER_BIT,
        parameter int DEBOUNCE_CYCLES = 1_000_000
) (
        input  wire        sys_clk_i,
        input  wire        arst_n_i,
        input  wire        uart_rx_i,
        output logic       uart_tx_o,
        input  wire [1:0]  key_button_i,
        input  wire [7:0]  fruit_number_i,
        input  wire [2:0]  color_i,
        output logic [2:0] led_out_o
);
        import fruit_pkg::*;

        // report byte handshake
        logic         tx_valid;
        logic         tx_ready;
        report_byte_t tx_data;
        // mode set request and current mode
        logic         mode_set;
        mode_e        mode_set_val;
        mode_e        mode_cur;

        uart_cmd_if u_cmd_if ();

        uart_rx_decode #(
                .CLKS_PER_BIT (CLKS_PER_BIT)
        ) u_uart_rx_decode (
                .sys_clk_i (sys_clk_i),
                .arst_n_i  (arst_n_i),
                .uart_rx_i (uart_rx_i),
                .cmd_o     (u_cmd_if.rx_side)
        );

        report_exec u_report_exec (
                .sys_clk_i      (sys_clk_i),
                .arst_n_i       (arst_n_i),
                .cmd_i          (u_cmd_if.exec_side),
                .mode_i         (mode_cur),
                .fruit_number_i (fruit_number_i),
                .color_i        (color_i),
                .tx_ready_i     (tx_ready),
                .mode_set_o     (mode_set),
                .mode_set_val_o (mode_set_val),
                .tx_valid_o     (tx_valid),
                .tx_data_o      (tx_data)
        );

        uart_tx_result #(
                .CLKS_PER_BIT (CLKS_PER_BIT)
        ) u_uart_tx_result (
                .sys_clk_i  (sys_clk_i),
                .arst_n_i   (arst_n_i),
                .tx_valid_i (tx_valid),
                .tx_data_i  (tx_data),
                .tx_ready_o (tx_ready),
                .uart_tx_o  (uart_tx_o)
        );

        mode_key_ctrl #(
                .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) u_mode_key_ctrl (
                .sys_clk_i      (sys_clk_i),
                .arst_n_i       (arst_n_i),
                .key_button_i   (key_button_i),
                .mode_set_i     (mode_set),
                .mode_set_val_i (mode_set_val),
                .mode_o         (mode_cur),
                .led_out_o      (led_out_o)
        );

endmodule

`default_nettype wire

//--- verif/tb_uart_tasks.svh
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// host side of the link, 8N1 lsb first, one bit every BIT_CLKS cycles
task automatic send_host_byte(input logic [7:0] data);
        logic [9:0] frame;
        // stop, data, start
        frame = {1'b1, data, 1'b0};
        @(negedge sys_clk);
        for (int i = 0; i < 10; i++) begin
                uart_rx = frame[i];
                repeat (BIT_CLKS) @(negedge sys_clk);
        end
endtask

// wait for a start edge, then sample each bit near its middle
task automatic capture_serial_byte(output logic [7:0] data);
        @(negedge uart_tx);
        repeat (BIT_CLKS / 2) @(negedge sys_clk);
        assert (uart_tx === 1'b0)
                else flag_mismatch("start bit not low at its middle");
        for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge sys_clk);
                data[i] = uart_tx;
        end
        repeat (BIT_CLKS) @(negedge sys_clk);
        assert (uart_tx === 1'b1)
                else flag_mismatch("stop bit not high at its middle");
endtask

`endif

//--- verif/tb_fruit_report_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fruit_report_top;
        // bit time and debounce length in clock cycles
        localparam int BIT_CLKS    = 16;
        localparam int DEB_CLKS    = 16;
        // roughly three times a dozen commands with their reports
        localparam int CYCLE_LIMIT = 40_000;
        // one report is forty bit times plus slack
        localparam int WAIT_LIMIT  = 60 * BIT_CLKS;

        logic       sys_clk;
        logic       arst_n;
        logic       uart_rx;
        wire        uart_tx;
        logic [1:0] key_button;
        logic [7:0] fruit_number;
        logic [2:0] color;
        wire  [2:0] led_out;

        // bytes seen on the report line
        logic [7:0] rx_q [$];
        int         seed;
        int         cycle_cnt;
        // expected mode code as carried in a report
        int         exp_mode;
        // windows where the line must stay high or the LEDs must not move
        logic       expect_idle;
        logic       led_frozen;

        fruit_report_top #(
                .CLKS_PER_BIT    (BIT_CLKS),
                .DEBOUNCE_CYCLES (DEB_CLKS)
        ) u_fruit_report_top (
                .sys_clk_i      (sys_clk),
                .arst_n_i       (arst_n),
                .uart_rx_i      (uart_rx),
                .uart_tx_o      (uart_tx),
                .key_button_i   (key_button),
                .fruit_number_i (fruit_number),
                .color_i        (color),
                .led_out_o      (led_out)
        );

        `include "tb_uart_tasks.svh"

        always #10 sys_clk = ~sys_clk;

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("TEST RESULT: FAIL");
                $fatal(1);
        endtask

        task automatic flag_mismatch(input string msg);
                abort_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
        endtask

        always @(posedge sys_clk) begin
                cycle_cnt++;
                if (cycle_cnt >= CYCLE_LIMIT)
                        abort_run($sformatf("timeout, run still going after %0d cycles",
                                            CYCLE_LIMIT));
        end

        // serial monitor
        initial begin
                logic [7:0] b;
                wait (arst_n === 1'b1);
                forever begin
                        capture_serial_byte(b);
                        rx_q.push_back(b);
                end
        end

        // mark line in quiet windows
        a_line_idle: assert property (@(posedge sys_clk) disable iff (!arst_n)
                expect_idle |-> uart_tx)
                else flag_mismatch("uart_tx_o left idle high");

        a_led_onehot: assert property (@(posedge sys_clk) disable iff (!arst_n)
                $onehot(led_out))
                else flag_mismatch($sformatf("led_out_o %03b not one-hot", led_out));

        a_led_frozen: assert property (@(posedge sys_clk) disable iff (!arst_n)
                led_frozen |-> led_out == 3'(1 << exp_mode))
                else flag_mismatch($sformatf("led_out_o moved to %03b", led_out));

        // payload rule per mode
        function automatic logic [7:0] expected_payload();
                case (exp_mode)
                0:       return fruit_number;
                1:       return {5'b0, color};
                default: return (fruit_number != 8'd0) ? 8'd1 : 8'd0;
                endcase
        endfunction

        task automatic wait_led(input string what);
                logic [2:0] exp_led;
                int         n;
                exp_led = 3'(1 << exp_mode);
                n = 0;
                while (led_out !== exp_led && n < WAIT_LIMIT) begin
                        @(negedge sys_clk);
                        n++;
                end
                assert (led_out === exp_led)
                        else flag_mismatch($sformatf("%s, led_out_o %03b, expected %03b",
                                                     what, led_out, exp_led));
        endtask

        task automatic set_mode(input int m);
                send_host_byte(8'h30 + 8'(m));
                exp_mode = m;
                wait_led($sformatf("set mode %0d", m));
        endtask

        task automatic press_key(input int idx, input int cycles);
                @(negedge sys_clk);
                key_button[idx] = 1'b0;
                repeat (cycles) @(negedge sys_clk);
                key_button[idx] = 1'b1;
        endtask

        task automatic run_query();
                logic [7:0] exp_bytes [4];
                int         n;
                exp_bytes[0] = 8'hA5;
                exp_bytes[1] = 8'(exp_mode);
                exp_bytes[2] = expected_payload();
                // sum modulo 256
                exp_bytes[3] = exp_bytes[0] + exp_bytes[1] + exp_bytes[2];
                rx_q.delete();
                send_host_byte(8'h51);
                n = 0;
                while (rx_q.size() < 4 && n < WAIT_LIMIT) begin
                        @(negedge sys_clk);
                        n++;
                end
                assert (rx_q.size() == 4)
                        else abort_run("report of four bytes did not arrive");
                for (int i = 0; i < 4; i++)
                        assert (rx_q[i] == exp_bytes[i])
                                else flag_mismatch(
                                        $sformatf("report byte %0d is %02h, expected %02h",
                                                  i, rx_q[i], exp_bytes[i]));
        endtask

        initial begin
                seed         = 9416;
                cycle_cnt    = 0;
                sys_clk      = 1'b0;
                arst_n       = 1'b0;
                uart_rx      = 1'b1;
                key_button   = 2'b11;
                fruit_number = 8'd0;
                color        = 3'd0;
                exp_mode     = 0;
                expect_idle  = 1'b1;
                led_frozen   = 1'b0;
                repeat (5) @(negedge sys_clk);
                arst_n = 1'b1;

                // quiet line and count mode after reset
                repeat (4 * BIT_CLKS) @(negedge sys_clk);
                wait_led("after reset");
                expect_idle  = 1'b0;
                fruit_number = 8'($random(seed));
                run_query();

                // color mode
                set_mode(1);
                color        = 3'($random(seed));
                fruit_number = 8'($random(seed));
                run_query();

                // detect mode with a zero then a nonzero count
                set_mode(2);
                fruit_number = 8'd0;
                run_query();
                fruit_number = 8'($random(seed));
                if (fruit_number == 8'd0)
                        fruit_number = 8'd1;
                run_query();

                // key 0 wraps detect to count
                press_key(0, 2 * DEB_CLKS);
                exp_mode = 0;
                wait_led("key 0 from detect");
                // key 1 steps back from count to detect
                press_key(1, 2 * DEB_CLKS);
                exp_mode = 2;
                wait_led("key 1 from count");

                // one cycle too short to count as a press
                led_frozen = 1'b1;
                press_key(0, DEB_CLKS - 1);
                repeat (2 * DEB_CLKS) @(negedge sys_clk);

                // unknown byte leaves the line quiet for twenty bit times
                expect_idle = 1'b1;
                rx_q.delete();
                send_host_byte(8'h7E);
                repeat (20 * BIT_CLKS) @(negedge sys_clk);
                assert (rx_q.size() == 0)
                        else flag_mismatch("report bytes after an unknown command");
                expect_idle = 1'b0;
                led_frozen  = 1'b0;
                wait_led("after unknown byte");

                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

`default_nettype wire

//--- fruit_report_top.f
+incdir+common
+incdir+verif
common/fruit_pkg.sv
common/uart_cmd_if.sv
uart/uart_rx_decode.sv
uart/uart_tx_result.sv
verilog/mode_key_ctrl.sv
verilog/report_exec.sv
verilog/fruit_report_top.sv
verif/tb_fruit_report_top.sv

//--- Bender.yml
package:
  name: fruit_report

sources:
  - include_dirs:
      - common
    files:
      - common/fruit_pkg.sv
      - common/uart_cmd_if.sv
      - uart/uart_rx_decode.sv
      - uart/uart_tx_result.sv
      - verilog/mode_key_ctrl.sv
      - verilog/report_exec.sv
      - verilog/fruit_report_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_fruit_report_top.sv
